//--- afu_control.f
+incdir+hdl
hdl/afu_control_pkg.sv
hdl/cmd_queue.sv
hdl/cmd_arbiter.sv
hdl/credit_counter.sv
hdl/tag_table.sv
hdl/issue_fsm.sv
hdl/afu_control_top.sv
bench/afu_control_assertions.sv
bench/afu_control_tb.sv

//--- bench/afu_control_assertions.sv
`timescale 1ns/100ps
`default_nettype none

module afu_control_assertions (
	input logic                       clock,
	input logic                       rstn,
	input logic                       host_req,
	input logic                       host_ack,
	input afu_control_pkg::host_cmd_t host_cmd
);

	int unsigned assert_fails = 0;

	// Req holds until the host acks
	req_held: assert property (@(posedge clock) disable iff (!rstn)
		host_req && !host_ack |=> host_req)
		else begin
			assert_fails++;
			$error("host_req dropped before host_ack rose");
		end

	// Payload frozen for the whole request phase
	cmd_stable: assert property (@(posedge clock) disable iff (!rstn)
		host_req ##1 host_req |-> $stable(host_cmd))
		else begin
			assert_fails++;
			$error("host_cmd changed while host_req was high");
		end

	req_after_release: assert property (@(posedge clock) disable iff (!rstn)
		$rose(host_req) |-> !host_ack)
		else begin
			assert_fails++;
			$error("host_req rose while host_ack was still high");
		end

endmodule

bind afu_control_top afu_control_assertions u_assertions (
	.clock(clock), .rstn(rstn), .host_req(host_req), .host_ack(host_ack),
	.host_cmd(host_cmd));

`default_nettype wire

//--- bench/afu_control_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "afu_control_consts.svh"

module afu_control_tb;

	localparam time CLK_PERIOD = 100ns;
	localparam int NUM_CMDS = 9;
	localparam int WATCHDOG_CYCLES = NUM_CMDS * 20 + 2000;

	typedef afu_control_pkg::cmd_line_t line_q_t [$];

	logic                                 clock;
	logic                                 rstn;
	logic                                 enable_in;
	afu_control_pkg::cmd_line_t           wed_cmd_in;
	afu_control_pkg::cmd_line_t           write_cmd_in;
	afu_control_pkg::cmd_line_t           read_cmd_in;
	logic                                 host_ack;
	afu_control_pkg::host_rsp_t           host_rsp_in;
	logic                                 host_req;
	afu_control_pkg::host_cmd_t           host_cmd;
	afu_control_pkg::afu_rsp_t            rsp_out;
	afu_control_pkg::queue_status_t [2:0] queue_status;

	line_q_t                     pushed;
	line_q_t                     exp_q;
	logic [`AFU_TAG_W-1:0]       outstanding [$];
	afu_control_pkg::cmd_class_t tag_cls [`AFU_NUM_TAGS];
	afu_control_pkg::host_rsp_t  rsp_seen;
	logic                        req_seen;
	int unsigned                 issue_count;
	int unsigned                 checks;
	int unsigned                 errors;

	afu_control_top dut (.clock(clock), .rstn(rstn), .enable_in(enable_in),
		.wed_cmd_in(wed_cmd_in), .write_cmd_in(write_cmd_in), .read_cmd_in(read_cmd_in),
		.host_ack(host_ack), .host_rsp_in(host_rsp_in), .host_req(host_req),
		.host_cmd(host_cmd), .rsp_out(rsp_out), .queue_status(queue_status));

	initial begin
		clock = 1'b0;
		forever #(CLK_PERIOD / 2) clock = ~clock;
	end

	task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
		input string msg);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("Fail at %0t: %s, got %0h expected %0h", $time, msg, actual, expected);
		end
	endtask

	function automatic afu_control_pkg::cmd_line_t make_line(
		input afu_control_pkg::cmd_class_t cls);
		afu_control_pkg::cmd_line_t line;
		line.valid   = 1'b1;
		line.cls     = cls;
		line.address = $urandom;
		line.size    = `AFU_SIZE_W'($urandom);
		return line;
	endfunction

	// Issue order when all lines are queued before any grant
	function automatic line_q_t expected_order(input line_q_t lines);
		afu_control_pkg::cmd_class_t prio [3];
		line_q_t                     order;
		int unsigned                 taken;
		prio = '{afu_control_pkg::CLASS_WED, afu_control_pkg::CLASS_WRITE,
			afu_control_pkg::CLASS_READ};
		foreach (prio[p]) begin
			taken = 0;
			foreach (lines[i]) begin
				if (lines[i].cls == prio[p] && taken < `AFU_QUEUE_DEPTH) begin
					order.push_back(lines[i]);
					taken++;
				end
			end
		end
		return order;
	endfunction

	// Bit 0 wed, bit 1 write, bit 2 read
	task automatic push_lines(input logic [2:0] which);
		afu_control_pkg::cmd_line_t lines [3];
		lines[0] = make_line(afu_control_pkg::CLASS_WED);
		lines[1] = make_line(afu_control_pkg::CLASS_WRITE);
		lines[2] = make_line(afu_control_pkg::CLASS_READ);
		foreach (lines[i]) begin
			if (which[i])
				pushed.push_back(lines[i]);
			else
				lines[i].valid = 1'b0;
		end
		@(posedge clock);
		wed_cmd_in   <= lines[0];
		write_cmd_in <= lines[1];
		read_cmd_in  <= lines[2];
	endtask

	task automatic queue_expected();
		line_q_t order;
		order = expected_order(pushed);
		foreach (order[i])
			exp_q.push_back(order[i]);
		pushed.delete();
	endtask

	task automatic send_response();
		afu_control_pkg::host_rsp_t rsp;
		rsp.valid = 1'b1;
		rsp.tag   = outstanding.pop_front();
		rsp.code  = `AFU_RSP_W'($urandom);
		@(posedge clock);
		host_rsp_in <= rsp;
		@(posedge clock);
		host_rsp_in <= '0;
	endtask

	task automatic wait_outstanding(input int unsigned n);
		while (outstanding.size() < n)
			@(posedge clock);
	endtask

	task automatic drain_responses();
		while (issue_count < NUM_CMDS || outstanding.size() != 0 || host_req || host_ack) begin
			if (outstanding.size() != 0)
				send_response();
			else
				@(posedge clock);
		end
	endtask

//////////////////////////////////////////////////////////////////////
// Host model and checker
//////////////////////////////////////////////////////////////////////

	initial begin
		host_ack = 1'b0;
		forever begin
			@(posedge clock);
			if (host_req && !host_ack) begin
				host_ack <= 1'b1;
				foreach (outstanding[i])
					check_value(outstanding[i] == host_cmd.tag, 1'b0, "tag already outstanding");
				outstanding.push_back(host_cmd.tag);
			end else if (!host_req && host_ack) begin
				host_ack <= 1'b0;
			end
		end
	end

	initial begin
		afu_control_pkg::cmd_line_t exp_line;
		req_seen = 1'b0;
		rsp_seen = '0;
		forever begin
			@(posedge clock);
			if (host_req && !req_seen) begin
				issue_count++;
				if (exp_q.size() == 0) begin
					errors++;
					$display("Command issued at %0t when none was expected", $time);
				end else begin
					exp_line = exp_q.pop_front();
					check_value(host_cmd.cls, exp_line.cls, "issued class");
					check_value(host_cmd.address, exp_line.address, "issued address");
					check_value(host_cmd.size, exp_line.size, "issued size");
					tag_cls[host_cmd.tag] = exp_line.cls;
				end
			end
			req_seen = host_req;
			// Routed response one cycle behind the host response
			check_value(rsp_out.valid, rsp_seen.valid, "rsp_out valid");
			if (rsp_seen.valid) begin
				check_value(rsp_out.tag, rsp_seen.tag, "rsp_out tag");
				check_value(rsp_out.code, rsp_seen.code, "rsp_out code");
				check_value(rsp_out.cls, tag_cls[rsp_seen.tag], "rsp_out class");
			end
			rsp_seen = host_rsp_in;
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clock);
		$display("Watchdog expired before all commands were issued and answered");
		$display("ERRORS FOUND");
		$finish;
	end

//////////////////////////////////////////////////////////////////////
// Test sequence
//////////////////////////////////////////////////////////////////////

	initial begin
		void'($urandom(32'h7fc70a9d));
		rstn         = 1'b0;
		enable_in    = 1'b0;
		wed_cmd_in   = '0;
		write_cmd_in = '0;
		read_cmd_in  = '0;
		host_rsp_in  = '0;
		checks       = 0;
		errors       = 0;
		issue_count  = 0;
		repeat (4) @(posedge clock);
		rstn <= 1'b1;
		repeat (2) @(posedge clock);

		// One line per class in the same cycle, held back while disabled
		push_lines(3'b111);
		push_lines(3'b000);
		queue_expected();
		repeat (10) @(posedge clock);
		check_value(issue_count, 0, "issue while enable low");
		check_value(queue_status[0].empty, 1'b0, "wed queue empty");
		@(posedge clock);
		enable_in <= 1'b1;
		wait_outstanding(3);
		repeat (3) send_response();
		repeat (3) @(posedge clock);

		// Write queue pushed past its depth with reads behind it
		@(posedge clock);
		enable_in <= 1'b0;
		repeat (3) @(posedge clock);
		push_lines(3'b110);
		push_lines(3'b110);
		push_lines(3'b010);
		push_lines(3'b010);
		push_lines(3'b010);
		push_lines(3'b000);
		queue_expected();
		@(posedge clock);
		check_value(queue_status[1].full, 1'b1, "write queue full");
		check_value(queue_status[2].empty, 1'b0, "read queue empty");
		check_value(issue_count, 3, "issue while enable low");
		enable_in <= 1'b1;

		// Credits run out until a response returns one
		wait_outstanding(`AFU_INIT_CREDITS);
		repeat (20) @(posedge clock);
		check_value(issue_count, 3 + `AFU_INIT_CREDITS, "issues with no response");
		send_response();
		wait_outstanding(`AFU_INIT_CREDITS);
		repeat (20) @(posedge clock);
		check_value(issue_count, 4 + `AFU_INIT_CREDITS, "issues after one response");
		drain_responses();
		repeat (3) @(posedge clock);
		check_value(exp_q.size(), 0, "expected commands never issued");
		check_value(queue_status[1].empty, 1'b1, "write queue empty at end");

		errors += dut.u_assertions.assert_fails;
		$display("Checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
			dut.u_assertions.assert_fails);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

//--- hdl/afu_control_consts.svh
`ifndef AFU_CONTROL_CONSTS_SVH
`define AFU_CONTROL_CONSTS_SVH

// Command fields
`define AFU_ADDR_W 32
`define AFU_SIZE_W 8

// Tag pool, one tag per outstanding host command
`define AFU_TAG_W 3
`define AFU_NUM_TAGS 8

// Entries in each class queue
`define AFU_QUEUE_DEPTH 4

// Host credits
`define AFU_INIT_CREDITS 4
`define AFU_CREDIT_W 4

// Host response code
`define AFU_RSP_W 2

`endif

//--- hdl/afu_control_pkg.sv
`default_nettype none

`include "afu_control_consts.svh"

package afu_control_pkg;

	// Command classes, listed in issue priority order
	typedef enum logic [1:0] {
		CLASS_WED   = 2'd0,
		CLASS_WRITE = 2'd1,
		CLASS_READ  = 2'd2
	} cmd_class_t;

	typedef enum logic [1:0] {
		ISSUE_IDLE    = 2'd0,
		ISSUE_REQ     = 2'd1,
		ISSUE_RELEASE = 2'd2
	} issue_state_t;

	typedef struct packed {
		logic                   valid;
		cmd_class_t             cls;
		logic [`AFU_ADDR_W-1:0] address;
		logic [`AFU_SIZE_W-1:0] size;
	} cmd_line_t;

	// Payload of the req/ack issue handshake
	typedef struct packed {
		cmd_class_t             cls;
		logic [`AFU_ADDR_W-1:0] address;
		logic [`AFU_SIZE_W-1:0] size;
		logic [`AFU_TAG_W-1:0]  tag;
	} host_cmd_t;

	typedef struct packed {
		logic                  valid;
		logic [`AFU_TAG_W-1:0] tag;
		logic [`AFU_RSP_W-1:0] code;
	} host_rsp_t;

	// Response after the tag lookup
	typedef struct packed {
		logic                  valid;
		cmd_class_t            cls;
		logic [`AFU_TAG_W-1:0] tag;
		logic [`AFU_RSP_W-1:0] code;
	} afu_rsp_t;

	typedef struct packed {
		logic empty;
		logic full;
	} queue_status_t;

endpackage

`default_nettype wire

//--- hdl/afu_control_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "afu_control_consts.svh"

module afu_control_top (
	input  logic                                clock,
	input  logic                                rstn,
	input  logic                                enable_in,
	input  afu_control_pkg::cmd_line_t          wed_cmd_in,
	input  afu_control_pkg::cmd_line_t          write_cmd_in,
	input  afu_control_pkg::cmd_line_t          read_cmd_in,
	input  logic                                host_ack,
	input  afu_control_pkg::host_rsp_t          host_rsp_in,
	output logic                                host_req,
	output afu_control_pkg::host_cmd_t          host_cmd,
	output afu_control_pkg::afu_rsp_t           rsp_out,
	output afu_control_pkg::queue_status_t [2:0] queue_status
);

	afu_control_pkg::cmd_line_t wed_head;
	afu_control_pkg::cmd_line_t write_head;
	afu_control_pkg::cmd_line_t read_head;
	afu_control_pkg::cmd_line_t selected;

	logic                  enable;
	logic                  wed_pop;
	logic                  write_pop;
	logic                  read_pop;
	logic                  grant_en;
	logic                  issue;
	logic                  credit_avail;
	logic                  tag_free;
	logic [`AFU_TAG_W-1:0] alloc_tag;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			enable <= 1'b0;
		else
			enable <= enable_in;
	end

	// Pop, tag allocation and credit spend all share this strobe
	assign issue = grant_en && selected.valid;

//////////////////////////////////////////////////////////////////////
// Class queues, status index 0 wed, 1 write, 2 read
//////////////////////////////////////////////////////////////////////

	cmd_queue u_wed_queue (.clock(clock), .rstn(rstn), .push_line(wed_cmd_in),
		.pop(wed_pop), .head(wed_head), .status(queue_status[0]));

	cmd_queue u_write_queue (.clock(clock), .rstn(rstn), .push_line(write_cmd_in),
		.pop(write_pop), .head(write_head), .status(queue_status[1]));

	cmd_queue u_read_queue (.clock(clock), .rstn(rstn), .push_line(read_cmd_in),
		.pop(read_pop), .head(read_head), .status(queue_status[2]));

//////////////////////////////////////////////////////////////////////
// Arbitration, credits, tags and issue
//////////////////////////////////////////////////////////////////////

	cmd_arbiter u_arbiter (.grant_en(grant_en), .wed_head(wed_head),
		.write_head(write_head), .read_head(read_head), .wed_pop(wed_pop),
		.write_pop(write_pop), .read_pop(read_pop), .selected(selected));

	credit_counter u_credits (.clock(clock), .rstn(rstn), .take(issue),
		.give(host_rsp_in.valid), .credit_avail(credit_avail));

	tag_table u_tags (.clock(clock), .rstn(rstn), .alloc(issue),
		.alloc_cls(selected.cls), .host_rsp_in(host_rsp_in), .alloc_tag(alloc_tag),
		.tag_free(tag_free), .rsp_out(rsp_out));

	issue_fsm u_issue (.clock(clock), .rstn(rstn), .enable(enable),
		.credit_avail(credit_avail), .tag_free(tag_free), .selected(selected),
		.alloc_tag(alloc_tag), .host_ack(host_ack), .grant_en(grant_en),
		.host_req(host_req), .host_cmd(host_cmd));

endmodule

`default_nettype wire

//--- hdl/cmd_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module cmd_arbiter (
	input  logic                       grant_en,
	input  afu_control_pkg::cmd_line_t wed_head,
	input  afu_control_pkg::cmd_line_t write_head,
	input  afu_control_pkg::cmd_line_t read_head,
	output logic                       wed_pop,
	output logic                       write_pop,
	output logic                       read_pop,
	output afu_control_pkg::cmd_line_t selected
);

//////////////////////////////////////////////////////////////////////
// Fixed priority, wed over write over read
//////////////////////////////////////////////////////////////////////

	always_comb begin
		wed_pop   = 1'b0;
		write_pop = 1'b0;
		read_pop  = 1'b0;
		selected  = '0;
		if (grant_en) begin
			if (wed_head.valid) begin
				wed_pop      = 1'b1;
				selected     = wed_head;
				selected.cls = afu_control_pkg::CLASS_WED;
			end else if (write_head.valid) begin
				write_pop    = 1'b1;
				selected     = write_head;
				selected.cls = afu_control_pkg::CLASS_WRITE;
			end else if (read_head.valid) begin
				read_pop     = 1'b1;
				selected     = read_head;
				// Class always follows the queue the line came from
				selected.cls = afu_control_pkg::CLASS_READ;
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/cmd_queue.sv
`timescale 1ns/100ps
`default_nettype none

`include "afu_control_consts.svh"

module cmd_queue #(
	parameter int DEPTH = `AFU_QUEUE_DEPTH
) (
	input  logic                           clock,
	input  logic                           rstn,
	input  afu_control_pkg::cmd_line_t     push_line,
	input  logic                           pop,
	output afu_control_pkg::cmd_line_t     head,
	output afu_control_pkg::queue_status_t status
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	afu_control_pkg::cmd_line_t mem [DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             do_push;
	logic             do_pop;

	assign status.empty = (count == '0);
	assign status.full  = (count == CNT_W'(DEPTH));

	// Push into a full queue and pop from an empty one are dropped
	assign do_push = push_line.valid && !status.full;
	assign do_pop  = pop && !status.empty;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (do_push)
			mem[wr_ptr] <= push_line;
	end

	// Head is valid exactly while something is stored
	always_comb begin
		head       = mem[rd_ptr];
		head.valid = !status.empty;
	end

endmodule

`default_nettype wire

//--- hdl/credit_counter.sv
`timescale 1ns/100ps
`default_nettype none

`include "afu_control_consts.svh"

module credit_counter (
	input  logic clock,
	input  logic rstn,
	input  logic take,
	input  logic give,
	output logic credit_avail
);

	logic [`AFU_CREDIT_W-1:0] credits;

	// Issue spends one credit, each host response returns one
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			credits <= `AFU_CREDIT_W'(`AFU_INIT_CREDITS);
		end else begin
			case ({take, give})
				2'b10:   credits <= credits - 1'b1;
				2'b01:   credits <= credits + 1'b1;
				// Both or neither leaves the count alone
				default: credits <= credits;
			endcase
		end
	end

	assign credit_avail = (credits != '0);

endmodule

`default_nettype wire

//--- hdl/issue_fsm.sv
`timescale 1ns/100ps
`default_nettype none

`include "afu_control_consts.svh"

module issue_fsm (
	input  logic                       clock,
	input  logic                       rstn,
	input  logic                       enable,
	input  logic                       credit_avail,
	input  logic                       tag_free,
	input  afu_control_pkg::cmd_line_t selected,
	input  logic [`AFU_TAG_W-1:0]      alloc_tag,
	input  logic                       host_ack,
	output logic                       grant_en,
	output logic                       host_req,
	output afu_control_pkg::host_cmd_t host_cmd
);

	afu_control_pkg::issue_state_t state;

	logic take_cmd;

//////////////////////////////////////////////////////////////////////
// Grant
//////////////////////////////////////////////////////////////////////

	// Only idle with enable, a credit and a free tag may take a command
	assign grant_en = (state == afu_control_pkg::ISSUE_IDLE) && enable &&
		credit_avail && tag_free;

	assign take_cmd = grant_en && selected.valid;

//////////////////////////////////////////////////////////////////////
// Four-phase handshake
//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state    <= afu_control_pkg::ISSUE_IDLE;
			host_req <= 1'b0;
		end else begin
			case (state)
				afu_control_pkg::ISSUE_IDLE: begin
					if (take_cmd) begin
						host_req <= 1'b1;
						state    <= afu_control_pkg::ISSUE_REQ;
					end
				end
				afu_control_pkg::ISSUE_REQ: begin
					// Hold req until the host acks
					if (host_ack) begin
						host_req <= 1'b0;
						state    <= afu_control_pkg::ISSUE_RELEASE;
					end
				end
				afu_control_pkg::ISSUE_RELEASE: begin
					// Wait for ack to drop before the next grant
					if (!host_ack)
						state <= afu_control_pkg::ISSUE_IDLE;
				end
				default: begin
					host_req <= 1'b0;
					state    <= afu_control_pkg::ISSUE_IDLE;
				end
			endcase
		end
	end

	// Command register, held for the whole handshake
	always_ff @(posedge clock) begin
		if (take_cmd) begin
			host_cmd.cls     <= selected.cls;
			host_cmd.address <= selected.address;
			host_cmd.size    <= selected.size;
			host_cmd.tag     <= alloc_tag;
		end
	end

endmodule

`default_nettype wire

//--- hdl/tag_table.sv
`timescale 1ns/100ps
`default_nettype none

`include "afu_control_consts.svh"

module tag_table (
	input  logic                           clock,
	input  logic                           rstn,
	input  logic                           alloc,
	input  afu_control_pkg::cmd_class_t    alloc_cls,
	input  afu_control_pkg::host_rsp_t     host_rsp_in,
	output logic [`AFU_TAG_W-1:0]          alloc_tag,
	output logic                           tag_free,
	output afu_control_pkg::afu_rsp_t      rsp_out
);

	logic [`AFU_NUM_TAGS-1:0] busy;

	afu_control_pkg::cmd_class_t cls_mem [`AFU_NUM_TAGS];

//////////////////////////////////////////////////////////////////////
// Lowest free tag
//////////////////////////////////////////////////////////////////////

	always_comb begin
		alloc_tag = '0;
		for (int i = `AFU_NUM_TAGS - 1; i >= 0; i--) begin
			if (!busy[i])
				alloc_tag = `AFU_TAG_W'(i);
		end
	end

	assign tag_free = !(&busy);

//////////////////////////////////////////////////////////////////////
// Busy bits
//////////////////////////////////////////////////////////////////////

	// Allocated tag is free and responding tag is busy, so they never collide
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			busy <= '0;
		end else begin
			if (alloc)
				busy[alloc_tag] <= 1'b1;
			if (host_rsp_in.valid)
				busy[host_rsp_in.tag] <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (alloc)
			cls_mem[alloc_tag] <= alloc_cls;
	end

//////////////////////////////////////////////////////////////////////
// Routed response
//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			rsp_out <= '0;
		end else begin
			rsp_out.valid <= host_rsp_in.valid;
			// Class of the command that owned this tag
			rsp_out.cls   <= cls_mem[host_rsp_in.tag];
			rsp_out.tag   <= host_rsp_in.tag;
			rsp_out.code  <= host_rsp_in.code;
		end
	end

endmodule

`default_nettype wire
